// ==== Bender.yml ====
package:
  name: rh11_regs

sources:
  - include_dirs:
      - hw
    files:
      - hw/rh_pkg.sv
      - hw/rh_bus_slave.sv
      - hw/rh_drive_exec.sv
      - hw/rh_intr.sv
      - hw/rh_top.sv
      - verification/rh_clock_gen.sv
      - verification/rh_tb.sv

// ==== files.f ====
+incdir+hw
hw/rh_pkg.sv
hw/rh_bus_slave.sv
hw/rh_drive_exec.sv
hw/rh_intr.sv
hw/rh_top.sv
verification/rh_clock_gen.sv
verification/rh_tb.sv

// ==== hw/rh_bus_slave.sv ====
// unibus msyn/ssyn slave; master holds address and data until ssyn, no DATIP support
`timescale 1ns/10ps
`include "rh_cfg.svh"

module rh_bus_slave (
    input  logic             CLOCK,
    input  logic             RESET,
    input  logic [17:0]      a_in,
    input  logic [1:0]       c_in,
    input  rh_pkg::word_t    d_in,
    input  logic             msyn,
    input  logic             init,
    output rh_pkg::word_t    d_out,
    output logic             ssyn,
    output logic             reg_wr,        // one cycle, same edge as ssyn rise
    output rh_pkg::reg_sel_t reg_sel,
    output logic             wr_hi,
    output logic             wr_lo,
    output rh_pkg::word_t    wdata,
    output rh_pkg::drive_t   sel_drive,
    output logic             ctl_clr,
    input  rh_pkg::word_t    drive_rdata,
    input  logic [7:0]       ata,
    input  logic             go_rejected,
    output logic             cs1_wr_lo,
    output logic             rdy,
    output logic             sc,
    input  logic             ie
);
    localparam logic [17:0] BASE = `RH_BASE_ADDR;

    logic          selected;
    logic          tre;
    logic [1:0]    a1716;           // rpcs1 bits 9..8
    logic          pge;             // program error
    logic          mxf;             // missed transfer
    logic          wce;             // write check error
    logic          nxm;             // nonexistent memory
    rh_pkg::word_t rdata;

    // new cycle only once the previous ssyn has dropped
    assign selected = msyn && !ssyn && (a_in[17:6] == BASE[17:6]);

    assign reg_wr  = selected && c_in[1] && !init;
    assign reg_sel = rh_pkg::reg_sel_t'(a_in[5:1]);
    assign wr_hi   = !c_in[0] || a_in[0];   // word, or byte to odd address
    assign wr_lo   = !c_in[0] || !a_in[0];  // word, or byte to even address
    assign wdata   = d_in;

    assign cs1_wr_lo = reg_wr && (reg_sel == rh_pkg::CS1) && wr_lo;
    // init or a 1 in rpcs2 CLR
    assign ctl_clr   = init || (reg_wr && (reg_sel == rh_pkg::CS2) && wr_lo && d_in[5]);

    assign rdy = 1'b1;                      // no transfers, controller never busy
    assign tre = wce || nxm || pge || mxf;
    assign sc  = tre || (|ata);

    // read mux, drive registers come from the executor
    always_comb begin
        case (reg_sel)
            rh_pkg::CS1: rdata = {sc, tre, 4'b0010, a1716, rdy, ie, drive_rdata[5:0]};
            rh_pkg::CS2: rdata = {1'b0, wce, 2'b00, nxm, pge, mxf, 6'b0, sel_drive};
            rh_pkg::AS:  rdata = {8'b0, ata};
            rh_pkg::DA,
            rh_pkg::DS,
            rh_pkg::ER1,
            rh_pkg::DT,
            rh_pkg::DC,
            rh_pkg::CC:  rdata = drive_rdata;
            default:     rdata = '0;        // wc, ba and unknown offsets
        endcase
    end

    // handshake
    always_ff @(posedge CLOCK) begin
        if (RESET || init) begin
            ssyn  <= 1'b0;
            d_out <= '0;
        end else if (ssyn && !msyn) begin   // master let go
            ssyn  <= 1'b0;
            d_out <= '0;
        end else if (selected) begin
            ssyn <= 1'b1;
            if (!c_in[1]) d_out <= rdata;
        end
    end

    // rpcs2 and the a17/a16 field
    always_ff @(posedge CLOCK) begin
        if (RESET || ctl_clr) begin
            sel_drive <= '0;
            a1716     <= '0;
            pge       <= 1'b0;
            mxf       <= 1'b0;
            wce       <= 1'b0;
            nxm       <= 1'b0;
        end else begin
            if (go_rejected) pge <= 1'b1;   // GO to a busy drive
            if (reg_wr && (reg_sel == rh_pkg::CS1) && wr_hi) begin
                a1716 <= d_in[9:8];
                if (d_in[14]) begin         // TRE write clears the error byte
                    pge <= 1'b0;
                    mxf <= 1'b0;
                    wce <= 1'b0;
                    nxm <= 1'b0;
                end
            end
            if (reg_wr && (reg_sel == rh_pkg::CS2)) begin
                if (wr_lo) sel_drive <= d_in[2:0];
                if (wr_hi) begin            // maintenance write of error bits
                    wce <= d_in[14];
                    nxm <= d_in[11];
                    mxf <= d_in[9];
                end
            end
        end
    end

endmodule

// ==== hw/rh_cfg.svh ====
// build-time constants for the rh11 block; the 3-bit unit field limits it to eight drives
`ifndef RH_CFG_SVH
`define RH_CFG_SVH

// unibus placement, decode looks at bits 17..6 only
`define RH_BASE_ADDR        18'o776700
`define RH_INT_VEC          8'o254

`define RH_NUM_DRIVES       8

// highest legal cylinder per drive type
`define RH_MAX_CYL_RP04     10'd410
`define RH_MAX_CYL_RP06     10'd814
`define RH_MAX_TRK          5'd18       // 19 tracks per cylinder
`define RH_MAX_SEC          5'd21       // 22 sectors per track

// seek timing in step ticks
`define RH_FIRST_STEP_TICKS 6'd41       // settle before first step
`define RH_TICK_BITS        11          // prescaler, counts full drive scans

`endif

// ==== hw/rh_drive_exec.sv ====
// per-drive registers and executor; serves one drive per idle clock and stalls on bus writes
`timescale 1ns/10ps
`include "rh_cfg.svh"

module rh_drive_exec (
    input  logic             CLOCK,
    input  logic             RESET,
    input  logic             reg_wr,
    input  rh_pkg::reg_sel_t reg_sel,
    input  logic             wr_hi,
    input  logic             wr_lo,
    input  rh_pkg::word_t    wdata,
    input  rh_pkg::drive_t   sel_drive,
    input  logic             ctl_clr,
    input  logic             fast_seek,
    input  logic [7:0]       drive_types,
    input  logic [7:0]       media_online,
    output rh_pkg::word_t    drive_rdata,
    output logic [7:0]       ata,
    output logic             go_rejected
);
    localparam int ND = `RH_NUM_DRIVES;

    rh_pkg::func_t            fc [ND];          // latched function code
    logic [ND-1:0]            go;
    logic [ND-1:0]            dry;              // drive ready
    logic [ND-1:0]            err;              // error summary
    logic [ND-1:0]            pip;              // positioning in progress
    logic [ND-1:0]            vv;               // volume valid
    logic [ND-1:0]            stepping;
    logic [5:0]               fst_cnt [ND];     // ticks toward first step
    rh_pkg::word_t            rpda [ND];
    rh_pkg::word_t            rper1 [ND];
    rh_pkg::cyl_t             rpdc [ND];
    rh_pkg::cyl_t             rpcc [ND];
    rh_pkg::drive_t           exeds;            // drive served this cycle
    logic [`RH_TICK_BITS-1:0] tick_cnt;
    logic                     tick;
    logic                     run;
    logic                     svc_go;
    rh_pkg::cyl_t             max_cyl;

    assign tick    = (tick_cnt == '0);          // whole scan sees the tick
    assign run     = !reg_wr && !ctl_clr;
    assign svc_go  = run && go[exeds] && !stepping[exeds];
    assign max_cyl = drive_types[exeds] ? `RH_MAX_CYL_RP06 : `RH_MAX_CYL_RP04;

    always_ff @(posedge CLOCK) begin
        if (RESET || ctl_clr) begin             // all drives at once
            fc          <= '{default: rh_pkg::NOP};
            go          <= '0;
            dry         <= '1;
            ata         <= '0;
            err         <= '0;
            pip         <= '0;
            stepping    <= '0;
            fst_cnt     <= '{default: '0};
            rper1       <= '{default: '0};
            rpdc        <= '{default: '0};
            rpcc        <= '{default: '0};
            exeds       <= '0;
            tick_cnt    <= '0;
            go_rejected <= 1'b0;
        end else if (reg_wr) begin
            go_rejected <= 1'b0;
            case (reg_sel)
                rh_pkg::CS1: if (wr_lo && wdata[0]) begin
                    if (dry[sel_drive]) begin   // accept GO
                        fc[sel_drive]  <= rh_pkg::func_t'(wdata[5:1]);
                        go[sel_drive]  <= 1'b1;
                        dry[sel_drive] <= 1'b0;
                    end else begin
                        go_rejected <= 1'b1;    // drive busy
                    end
                end
                rh_pkg::ER1: begin
                    if (wr_hi) rper1[sel_drive][15:8] <= wdata[15:8];
                    if (wr_lo) rper1[sel_drive][7:0] <= wdata[7:0];
                end
                rh_pkg::AS: if (wr_lo) ata <= ata & ~wdata[7:0];   // write 1 to clear
                rh_pkg::DC: begin
                    if (wr_hi) rpdc[sel_drive][9:8] <= wdata[9:8];
                    if (wr_lo) rpdc[sel_drive][7:0] <= wdata[7:0];
                end
                default: ;
            endcase
        end else begin
            go_rejected <= 1'b0;
            if (stepping[exeds]) begin
                if (tick) begin
                    if (rpcc[exeds] == rpdc[exeds]) begin
                        stepping[exeds] <= 1'b0;    // arrived, seek case finishes next pass
                    end else if (fst_cnt[exeds] != `RH_FIRST_STEP_TICKS) begin
                        fst_cnt[exeds] <= fst_cnt[exeds] + 1'b1;
                    end else if (rpcc[exeds] < rpdc[exeds]) begin
                        rpcc[exeds] <= rpcc[exeds] + 1'b1;     // step inward
                    end else begin
                        rpcc[exeds] <= rpcc[exeds] - 1'b1;     // step outward
                    end
                end
            end else if (go[exeds]) begin
                go[exeds]  <= 1'b0;             // default, seek in motion overrides
                dry[exeds] <= 1'b1;
                case (fc[exeds])
                    rh_pkg::NOP: ;
                    rh_pkg::SEEK,
                    rh_pkg::SEARCH: begin
                        if (rpdc[exeds] > max_cyl) begin
                            rper1[exeds][10] <= 1'b1;   // IAE
                            err[exeds]       <= 1'b1;
                            ata[exeds]       <= 1'b1;
                        end else if (rpcc[exeds] != rpdc[exeds]) begin
                            go[exeds]       <= 1'b1;    // keep busy while stepping
                            dry[exeds]      <= 1'b0;
                            pip[exeds]      <= 1'b1;
                            stepping[exeds] <= 1'b1;
                            fst_cnt[exeds]  <= '0;
                        end else begin
                            pip[exeds] <= 1'b0;         // on cylinder
                            ata[exeds] <= 1'b1;
                        end
                    end
                    rh_pkg::DCLR,
                    rh_pkg::RELEASE: begin
                        ata[exeds]   <= 1'b0;
                        err[exeds]   <= 1'b0;
                        rper1[exeds] <= '0;
                    end
                    rh_pkg::PRESET: rpdc[exeds] <= '0;  // vv and rpda in own blocks
                    rh_pkg::PACKACK: ;
                    default: begin                      // transfers and the rest
                        rper1[exeds][0] <= 1'b1;        // ILF
                        err[exeds]      <= 1'b1;
                        ata[exeds]      <= 1'b1;
                    end
                endcase
            end
            if (exeds == ND - 1) tick_cnt <= fast_seek ? '0 : tick_cnt + 1'b1;
            exeds <= exeds + 1'b1;
        end
    end

    // sector/track address, survives controller clear
    always_ff @(posedge CLOCK) begin
        if (reg_wr && (reg_sel == rh_pkg::DA)) begin
            if (wr_hi) rpda[sel_drive][15:8] <= wdata[15:8];
            if (wr_lo) rpda[sel_drive][7:0] <= wdata[7:0];
        end else if (svc_go && (fc[exeds] == rh_pkg::PRESET)) begin
            rpda[exeds] <= '0;
        end
    end

    // volume valid, only power-up reset drops it
    always_ff @(posedge CLOCK) begin
        if (RESET) vv <= '0;
        else if (svc_go && (fc[exeds] == rh_pkg::PRESET || fc[exeds] == rh_pkg::PACKACK))
            vv[exeds] <= 1'b1;
    end

    always_comb begin
        case (reg_sel)
            rh_pkg::CS1: drive_rdata = {10'b0, fc[sel_drive], go[sel_drive]};
            rh_pkg::DA:  drive_rdata = rpda[sel_drive];
            // ata err pip mol wrl lst pgm dpr dry vv
            rh_pkg::DS:  drive_rdata = {ata[sel_drive], err[sel_drive], pip[sel_drive],
                                        media_online[sel_drive], 3'b000, 1'b1,
                                        dry[sel_drive], vv[sel_drive], 6'b0};
            rh_pkg::ER1: drive_rdata = rper1[sel_drive];
            rh_pkg::DT:  drive_rdata = drive_types[sel_drive] ? 16'o020022 : 16'o020020;
            rh_pkg::DC:  drive_rdata = {6'b0, rpdc[sel_drive]};
            rh_pkg::CC:  drive_rdata = {6'b0, rpcc[sel_drive]};
            default:     drive_rdata = '0;
        endcase
    end

endmodule

// ==== hw/rh_intr.sv ====
// rh11 edge-triggered interrupt; a grant clears IE as well as the request
`timescale 1ns/10ps
`include "rh_cfg.svh"

module rh_intr (
    input  logic          CLOCK,
    input  logic          RESET,
    input  logic          ctl_clr,
    input  logic          cs1_wr_lo,
    input  rh_pkg::word_t wdata,
    input  logic          rdy,
    input  logic          sc,
    input  logic          intgnt,
    input  logic [7:0]    igvec,
    output logic          ie,
    output logic          intreq
);
    logic last_rdy;
    logic last_sc;
    logic grant;

    assign grant = intgnt && (igvec == `RH_INT_VEC);   // ignore grants for other vectors

    always_ff @(posedge CLOCK) begin
        if (RESET || ctl_clr) begin
            ie       <= 1'b0;
            intreq   <= 1'b0;
            last_rdy <= 1'b1;                   // rdy idles high
            last_sc  <= 1'b0;
        end else begin
            last_rdy <= rdy;
            last_sc  <= sc;
            if (grant) ie <= 1'b0;
            else if (cs1_wr_lo) ie <= wdata[6];
            if (grant) intreq <= 1'b0;
            else if (ie && sc && !last_sc) intreq <= 1'b1;      // attention or error
            else if (ie && rdy && !last_rdy) intreq <= 1'b1;    // controller ready
            else if (cs1_wr_lo) begin
                if (!wdata[6]) intreq <= 1'b0;  // IE off drops pending
                else if (wdata[7]) intreq <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/rh_pkg.sv ====
// shared types for the rh11 block; register offsets are unibus word offsets from the base
package rh_pkg;

    typedef logic [15:0] word_t;    // one unibus data word
    typedef logic [2:0]  drive_t;   // drive number, same as rpcs2 unit field
    typedef logic [9:0]  cyl_t;     // cylinder, covers rp06 range

    // a[5:1] of the access
    typedef enum logic [4:0] {
        CS1 = 5'd0,     // control/status 1
        WC  = 5'd1,     // word count, reads zero here
        BA  = 5'd2,     // bus address, reads zero here
        DA  = 5'd3,     // desired sector/track
        CS2 = 5'd4,     // control/status 2
        DS  = 5'd5,     // drive status
        ER1 = 5'd6,     // error 1
        AS  = 5'd7,     // attention summary
        DT  = 5'd11,    // drive type
        DC  = 5'd14,    // desired cylinder
        CC  = 5'd15     // current cylinder
    } reg_sel_t;

    // rpcs1 fc field, bits 5..1, GO not included
    typedef enum logic [4:0] {
        NOP     = 5'd0,
        SEEK    = 5'd2,
        DCLR    = 5'd4,     // drive clear
        RELEASE = 5'd5,
        PRESET  = 5'd8,     // read-in preset
        PACKACK = 5'd9,
        SEARCH  = 5'd12     // treated as seek
    } func_t;

endpackage

// ==== hw/rh_top.sv ====
// rh11 register block top; always enabled, no data transfers, irvec fixed by the cfg header
`timescale 1ns/10ps
`include "rh_cfg.svh"

module rh_top (
    input  logic          CLOCK,
    input  logic          RESET,
    input  logic [17:0]   a_in,
    input  logic [1:0]    c_in,         // [1] write, [0] byte
    input  rh_pkg::word_t d_in,
    input  logic          msyn,
    input  logic          init,
    output rh_pkg::word_t d_out,
    output logic          ssyn,
    output logic          intreq,
    output logic [7:0]    irvec,
    input  logic          intgnt,
    input  logic [7:0]    igvec,
    input  logic          fast_seek,
    input  logic [7:0]    drive_types,  // 1 = rp06
    input  logic [7:0]    media_online
);
    // slave to executor
    logic              reg_wr;
    rh_pkg::reg_sel_t  reg_sel;
    logic              wr_hi;
    logic              wr_lo;
    rh_pkg::word_t     wdata;
    rh_pkg::drive_t    sel_drive;
    logic              ctl_clr;
    // executor back to slave
    rh_pkg::word_t     drive_rdata;
    logic [7:0]        ata;
    logic              go_rejected;
    // slave and interrupt unit
    logic              cs1_wr_lo;
    logic              rdy;
    logic              sc;
    logic              ie;

    assign irvec = `RH_INT_VEC;

    rh_bus_slave bus_slave_i (
        .CLOCK(CLOCK), .RESET(RESET),
        .a_in(a_in), .c_in(c_in), .d_in(d_in), .msyn(msyn), .init(init),
        .d_out(d_out), .ssyn(ssyn),
        .reg_wr(reg_wr), .reg_sel(reg_sel), .wr_hi(wr_hi), .wr_lo(wr_lo),
        .wdata(wdata), .sel_drive(sel_drive), .ctl_clr(ctl_clr),
        .drive_rdata(drive_rdata), .ata(ata), .go_rejected(go_rejected),
        .cs1_wr_lo(cs1_wr_lo), .rdy(rdy), .sc(sc), .ie(ie)
    );

    rh_drive_exec drive_exec_i (
        .CLOCK(CLOCK), .RESET(RESET),
        .reg_wr(reg_wr), .reg_sel(reg_sel), .wr_hi(wr_hi), .wr_lo(wr_lo),
        .wdata(wdata), .sel_drive(sel_drive), .ctl_clr(ctl_clr),
        .fast_seek(fast_seek), .drive_types(drive_types), .media_online(media_online),
        .drive_rdata(drive_rdata), .ata(ata), .go_rejected(go_rejected)
    );

    rh_intr intr_i (
        .CLOCK(CLOCK), .RESET(RESET), .ctl_clr(ctl_clr),
        .cs1_wr_lo(cs1_wr_lo), .wdata(wdata), .rdy(rdy), .sc(sc),
        .intgnt(intgnt), .igvec(igvec),
        .ie(ie), .intreq(intreq)
    );

endmodule

// ==== verification/rh_clock_gen.sv ====
// testbench clock and reset; 100 ns period, RESET high over the first 4 rising edges
`timescale 1ns/10ps

module rh_clock_gen (
    output logic CLOCK,
    output logic RESET
);
    initial begin
        CLOCK = 1'b0;
        forever #50 CLOCK = ~CLOCK;     // 100 ns period
    end

    initial begin
        RESET = 1'b1;
        repeat (4) @(posedge CLOCK);
        @(negedge CLOCK) RESET = 1'b0;  // release between edges
    end
endmodule

// ==== verification/rh_tb.sv ====
// rh_top testbench; fast seek only, drive types and media fixed per run, init never pulsed
`timescale 1ns/10ps
`include "rh_cfg.svh"

module rh_tb;
    localparam int N_TESTS     = 6;
    localparam int MAX_POLLS   = 200;
    localparam int POLL_CYCLES = 40;
    localparam int WATCHDOG_NS = (N_TESTS + 1) * MAX_POLLS * POLL_CYCLES * 100; // +1 for setup
    localparam logic [17:0] BASE = `RH_BASE_ADDR;
    localparam logic [4:0] RD_DATA = 5'd28;     // read data, rejected as illegal

    logic        CLOCK;
    logic        RESET;
    logic [17:0] a_in;
    logic [1:0]  c_in;
    logic [15:0] d_in, d_out, rd, w;
    logic        msyn, init, ssyn, intreq, intgnt, fast_seek;
    logic [7:0]  irvec, igvec, drive_types, media_online, b;
    logic [9:0]  cyl;
    integer      seed;
    int          errors, checks, d, d2;
    // reference model of the drives
    logic [15:0] m_rpda [8];
    logic [15:0] m_rper1 [8];
    logic [9:0]  m_rpdc [8];
    logic [9:0]  m_rpcc [8];
    logic [7:0]  m_ata, m_err, m_vv;

    rh_clock_gen clock_gen_i (.CLOCK(CLOCK), .RESET(RESET));

    rh_top rh_top_i (
        .CLOCK(CLOCK), .RESET(RESET), .a_in(a_in), .c_in(c_in), .d_in(d_in),
        .msyn(msyn), .init(init), .d_out(d_out), .ssyn(ssyn), .intreq(intreq),
        .irvec(irvec), .intgnt(intgnt), .igvec(igvec), .fast_seek(fast_seek),
        .drive_types(drive_types), .media_online(media_online)
    );

    function automatic logic [9:0] max_cyl(input int n);
        return drive_types[n] ? `RH_MAX_CYL_RP06 : `RH_MAX_CYL_RP04;
    endfunction

    // {iae, cylinder the drive ends on}
    function automatic logic [10:0] seek_result(input int n);
        if (m_rpdc[n] > max_cyl(n)) return {1'b1, m_rpcc[n]};
        return {1'b0, m_rpdc[n]};
    endfunction

    // ata err pip mol wrl lst pgm dpr dry vv, low six bits zero
    function automatic logic [15:0] exp_rpds(input int n, input logic busy);
        return {m_ata[n], m_err[n], busy, media_online[n], 3'b000, 1'b1,
                !busy, m_vv[n], 6'b0};
    endfunction

    function automatic logic [15:0] exp_rpdt(input int n);
        return drive_types[n] ? 16'o020022 : 16'o020020;   // rp06 : rp04
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // one msyn/ssyn cycle, everything driven on the falling edge
    task automatic bus_cycle(input logic [4:0] off, input logic [1:0] ctl, input logic odd,
                             input logic [15:0] wd, output logic [15:0] rdata);
        int n;
        @(negedge CLOCK);
        a_in = {BASE[17:6], off, odd};
        c_in = ctl;
        d_in = wd;
        msyn = 1'b1;
        for (n = 0; !ssyn && n < 16; n++) @(negedge CLOCK);
        if (!ssyn) begin
            errors++;
            $display("bus access to offset %0d was never answered with ssyn", off);
        end
        rdata = d_out;              // stable while ssyn high
        msyn  = 1'b0;
        for (n = 0; ssyn && n < 16; n++) @(negedge CLOCK);
        if (ssyn) begin
            errors++;
            $display("ssyn stayed high after msyn was released");
        end
    endtask

    task automatic write_reg(input logic [4:0] off, input logic [15:0] wd);
        logic [15:0] unused;
        bus_cycle(off, 2'b10, 1'b0, wd, unused);
    endtask

    // other lane carries the inverse so a wrong lane shows up
    task automatic write_byte(input logic [4:0] off, input logic odd, input logic [7:0] v);
        logic [15:0] unused;
        bus_cycle(off, 2'b11, odd, odd ? {v, ~v} : {~v, v}, unused);
    endtask

    task automatic read_reg(input logic [4:0] off, output logic [15:0] rdata);
        bus_cycle(off, 2'b00, 1'b0, 16'h0, rdata);
    endtask

    task automatic start_func(input int n, input logic [4:0] fc, input logic ie);
        write_reg(rh_pkg::CS2, 16'(n));
        write_reg(rh_pkg::CS1, {9'b0, ie, fc, 1'b1});
    endtask

    task automatic set_cyl(input int n, input logic [9:0] c);
        write_reg(rh_pkg::CS2, 16'(n));
        write_reg(rh_pkg::DC, {6'b0, c});
        m_rpdc[n] = c;
    endtask

    task automatic pick_cyl(input int n, output logic [9:0] c);
        c = {$random(seed)} % (max_cyl(n) + 1);
        if (c == m_rpcc[n]) c = (c == 0) ? 10'd1 : c - 10'd1;   // seek has to move
    endtask

    // polls rpds DRY of the selected drive
    task automatic wait_ready(input string name);
        logic [15:0] ds;
        int n;
        read_reg(rh_pkg::DS, ds);
        for (n = 0; !ds[7] && n < MAX_POLLS; n++) begin
            repeat (POLL_CYCLES) @(negedge CLOCK);
            read_reg(rh_pkg::DS, ds);
        end
        if (!ds[7]) begin
            errors++;
            $display("%s: drive did not return to ready within %0d polls", name, MAX_POLLS);
        end
    endtask

    task automatic finish_seek(input int n, input string name);
        logic [10:0] r;
        wait_ready(name);
        r = seek_result(n);
        if (r[10]) begin
            m_rper1[n][10] = 1'b1;  // IAE
            m_err[n] = 1'b1;
        end else begin
            m_rpcc[n] = r[9:0];
        end
        m_ata[n] = 1'b1;
    endtask

    initial begin
        seed = 32'hc3abf053;
        errors = 0;
        checks = 0;
        a_in = '0;
        c_in = '0;
        d_in = '0;
        msyn = 1'b0;
        init = 1'b0;
        intgnt = 1'b0;
        igvec = '0;
        fast_seek = 1'b1;
        drive_types = 8'b1010_0110;
        media_online = 8'b1101_1111;
        m_ata = '0;
        m_err = '0;
        m_vv = '0;
        for (int i = 0; i < 8; i++) begin
            m_rper1[i] = '0;
            m_rpdc[i] = '0;
            m_rpcc[i] = '0;
        end
        wait (!RESET);

        // byte lanes on rpda and rpdc, drive type
        d = $random(seed) & 7;
        write_reg(rh_pkg::CS2, 16'(d));
        m_rpda[d] = $random(seed);
        write_reg(rh_pkg::DA, m_rpda[d]);
        read_reg(rh_pkg::DA, rd);
        check_value("rpda word", m_rpda[d], rd);
        b = $random(seed);
        write_byte(rh_pkg::DA, 1'b0, b);
        m_rpda[d][7:0] = b;         // even byte, low lane only
        read_reg(rh_pkg::DA, rd);
        check_value("rpda low byte", m_rpda[d], rd);
        b = $random(seed);
        write_byte(rh_pkg::DA, 1'b1, b);
        m_rpda[d][15:8] = b;
        read_reg(rh_pkg::DA, rd);
        check_value("rpda high byte", m_rpda[d], rd);
        w = $random(seed);
        write_reg(rh_pkg::DC, w);
        m_rpdc[d] = w[9:0];         // ten bits of cylinder
        read_reg(rh_pkg::DC, rd);
        check_value("rpdc word", {6'b0, m_rpdc[d]}, rd);
        b = $random(seed);
        write_byte(rh_pkg::DC, 1'b1, b);
        m_rpdc[d][9:8] = b[1:0];
        read_reg(rh_pkg::DC, rd);
        check_value("rpdc high byte", {6'b0, m_rpdc[d]}, rd);
        read_reg(rh_pkg::DT, rd);
        check_value("rpdt", exp_rpdt(d), rd);

        // seek to a legal cylinder, then clear its attention
        d = $random(seed) & 7;
        pick_cyl(d, cyl);
        set_cyl(d, cyl);
        start_func(d, rh_pkg::SEEK, 1'b0);
        finish_seek(d, "seek");
        read_reg(rh_pkg::DS, rd);
        check_value("rpds after seek", exp_rpds(d, 1'b0), rd);
        read_reg(rh_pkg::CC, rd);
        check_value("rpcc after seek", {6'b0, m_rpdc[d]}, rd);
        read_reg(rh_pkg::AS, rd);
        check_value("rpas after seek", {8'b0, m_ata}, rd);
        read_reg(rh_pkg::CS1, rd);
        check_value("rpcs1 sc", 16'd1, rd[15]);
        write_reg(rh_pkg::AS, 16'(1 << d));
        m_ata[d] = 1'b0;
        read_reg(rh_pkg::AS, rd);
        check_value("rpas cleared", {8'b0, m_ata}, rd);

        // seek past the last cylinder, then drive clear
        d = $random(seed) & 7;
        cyl = max_cyl(d) + 1 + ({$random(seed)} % (1023 - max_cyl(d)));
        set_cyl(d, cyl);
        start_func(d, rh_pkg::SEEK, 1'b0);
        finish_seek(d, "illegal seek");
        read_reg(rh_pkg::ER1, rd);
        check_value("rper1 iae", m_rper1[d], rd);
        read_reg(rh_pkg::DS, rd);
        check_value("rpds after illegal seek", exp_rpds(d, 1'b0), rd);
        start_func(d, rh_pkg::DCLR, 1'b0);
        wait_ready("drive clear");
        m_ata[d] = 1'b0;
        m_err[d] = 1'b0;
        m_rper1[d] = '0;
        read_reg(rh_pkg::ER1, rd);
        check_value("rper1 after drive clear", m_rper1[d], rd);
        read_reg(rh_pkg::DS, rd);
        check_value("rpds after drive clear", exp_rpds(d, 1'b0), rd);

        // GO to a busy drive, then an unsupported function
        d = $random(seed) & 7;
        pick_cyl(d, cyl);
        set_cyl(d, cyl);
        start_func(d, rh_pkg::SEEK, 1'b0);
        write_reg(rh_pkg::CS1, 16'd1);      // nop GO while stepping
        read_reg(rh_pkg::CS2, rd);
        check_value("rpcs2 pge", 16'd1, rd[10]);
        read_reg(rh_pkg::CS1, rd);
        check_value("rpcs1 tre", 16'd1, rd[14]);
        write_reg(rh_pkg::CS1, 16'o040000); // TRE clears the error byte
        read_reg(rh_pkg::CS2, rd);
        check_value("rpcs2 pge cleared", 16'd0, rd[10]);
        read_reg(rh_pkg::CS1, rd);
        check_value("rpcs1 tre cleared", 16'd0, rd[14]);
        finish_seek(d, "seek with pge");
        start_func(d, RD_DATA, 1'b0);
        wait_ready("read data");
        m_rper1[d][0] = 1'b1;       // ILF
        m_err[d] = 1'b1;
        m_ata[d] = 1'b1;
        read_reg(rh_pkg::ER1, rd);
        check_value("rper1 ilf", m_rper1[d], rd);
        read_reg(rh_pkg::DS, rd);
        check_value("rpds after read data", exp_rpds(d, 1'b0), rd);
        read_reg(rh_pkg::CS1, rd);
        check_value("rpcs1 go after read data", 16'd0, rd[0]);

        // interrupt on seek done, grants with wrong and right vector
        write_reg(rh_pkg::AS, 16'h00ff);
        m_ata = '0;                 // sc low so the edge is seen
        check_value("intreq idle", 16'd0, intreq);
        d = $random(seed) & 7;
        pick_cyl(d, cyl);
        set_cyl(d, cyl);
        start_func(d, rh_pkg::SEEK, 1'b1);
        finish_seek(d, "seek with ie");
        check_value("intreq after seek", 16'd1, intreq);
        check_value("irvec", `RH_INT_VEC, irvec);
        igvec = 8'o250;
        intgnt = 1'b1;
        @(negedge CLOCK) intgnt = 1'b0;
        check_value("intreq after foreign grant", 16'd1, intreq);
        igvec = `RH_INT_VEC;
        intgnt = 1'b1;
        @(negedge CLOCK) intgnt = 1'b0;
        check_value("intreq after grant", 16'd0, intreq);
        read_reg(rh_pkg::CS1, rd);
        check_value("rpcs1 ie after grant", 16'd0, rd[6]);

        // pack acknowledge, then controller clear over all drives
        d = $random(seed) & 7;
        start_func(d, rh_pkg::PACKACK, 1'b0);
        wait_ready("pack acknowledge");
        m_vv[d] = 1'b1;
        read_reg(rh_pkg::DS, rd);
        check_value("rpds vv", exp_rpds(d, 1'b0), rd);
        d2 = (d + 1) % 8;
        pick_cyl(d2, cyl);
        set_cyl(d2, cyl);
        start_func(d2, rh_pkg::SEEK, 1'b0);
        repeat (16) @(negedge CLOCK);       // two drive scans, seek now stepping
        read_reg(rh_pkg::DS, rd);
        check_value("rpds while seeking", exp_rpds(d2, 1'b1), rd);
        write_reg(rh_pkg::CS2, 16'o000040);
        m_ata = '0;
        m_err = '0;
        for (int i = 0; i < 8; i++) begin
            m_rpcc[i] = '0;
            m_rpdc[i] = '0;
            m_rper1[i] = '0;
            write_reg(rh_pkg::CS2, 16'(i));
            read_reg(rh_pkg::DS, rd);
            check_value($sformatf("rpds drive %0d after clear", i), exp_rpds(i, 1'b0), rd);
            read_reg(rh_pkg::CC, rd);
            check_value($sformatf("rpcc drive %0d after clear", i), {6'b0, m_rpcc[i]}, rd);
            read_reg(rh_pkg::DC, rd);
            check_value($sformatf("rpdc drive %0d after clear", i), {6'b0, m_rpdc[i]}, rd);
            read_reg(rh_pkg::DT, rd);
            check_value($sformatf("rpdt drive %0d after clear", i), exp_rpdt(i), rd);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) $display("Done: no errors");
        else $display("Done: errors found");
        $finish;
    end

    // longest seek fits in one poll budget per test
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not end within %0d ns, %0d errors so far", WATCHDOG_NS, errors);
        $display("Done: errors found");
        $finish;
    end
endmodule
